// File: rtl/mbus_pkg.sv
// ----------------------------------------------------------
// Shared types and constants for the station bus data link
// CRC-8 is poly 0x07 with zero init, no reflection, no final XOR
// ----------------------------------------------------------
package mbus_pkg;

    // ----------------------------------------------------------
    // Line timing
    // ----------------------------------------------------------
    // sys_clk cycles per line bit
    localparam int BIT_CYCLES  = 8;
    // Receiver sample point inside a bit period
    localparam int SAMPLE_AT   = BIT_CYCLES / 2;
    // Start bit, eight data bits, stop bit
    localparam int BYTE_BITS   = 10;

    // ----------------------------------------------------------
    // Frame layout
    // ----------------------------------------------------------
    // Header, four data bytes, CRC
    localparam int FRAME_BYTES = 6;
    localparam int DATA_BYTES  = 4;

    // Counter widths
    localparam int CYC_W       = $clog2(BIT_CYCLES);
    localparam int BIT_W       = $clog2(BYTE_BITS);
    localparam int BYTE_W      = $clog2(FRAME_BYTES);
    localparam int COUNT_W     = 16;

    localparam logic [7:0] CRC_POLY = 8'h07;
    localparam logic [7:0] CRC_INIT = 8'h00;

    // Application frame without CRC
    // data[7:0] is data byte 0, first on the line after the header
    typedef struct packed {
        logic [7:0]              header;
        logic [DATA_BYTES*8-1:0] data;
    } mbus_frame_t;

    // Received frame with check result
    typedef struct packed {
        mbus_frame_t frame;
        logic        crc_err;
    } mbus_rx_t;

    // Link statistics, both counters saturate
    typedef struct packed {
        logic [COUNT_W-1:0] good_count;
        logic [COUNT_W-1:0] err_count;
    } mbus_stats_t;

    // Advance a CRC-8 by one byte, MSB first
    function automatic logic [7:0] crc8_byte(input logic [7:0] crc,
                                             input logic [7:0] data);
        logic [7:0] c;
        c = crc ^ data;
        for (int i = 0; i < 8; i++) begin
            // Shift out the top bit, fold in the polynomial when it was set
            c = c[7] ? ((c << 1) ^ CRC_POLY) : (c << 1);
        end
        return c;
    endfunction

endpackage

// File: rtl/mbus_tx_serializer.sv
`timescale 1ns/1ns
// ----------------------------------------------------------
// Frame transmitter, six back to back bytes per request
// Requests while busy are dropped without any queue
// ----------------------------------------------------------
module mbus_tx_serializer (
    input  logic                  sys_clk,
    input  logic                  reset,
    input  logic                  tx_req,
    input  mbus_pkg::mbus_frame_t tx_frame,
    output logic                  tx_busy,
    output logic                  line_tx,
    output logic                  line_txen
);
    import mbus_pkg::*;

    logic                    busy_q;
    logic [CYC_W-1:0]        cyc_q;
    logic [BIT_W-1:0]        bit_q;
    logic [BYTE_W-1:0]       byte_q;
    // Data bytes still to send, next one in the low byte
    logic [DATA_BYTES*8-1:0] data_q;
    logic [7:0]              crc_q;
    // Current byte with start and stop, line bit in bit 0
    logic [BYTE_BITS-1:0]    sh_q;
    logic                    accept;
    logic                    bit_end;
    logic                    byte_end;
    logic [7:0]              next_byte;

    assign accept    = tx_req && !busy_q;
    assign bit_end   = busy_q && (cyc_q == CYC_W'(BIT_CYCLES - 1));
    assign byte_end  = bit_end && (bit_q == BIT_W'(BYTE_BITS - 1));
    // CRC goes out after the last data byte
    assign next_byte = (byte_q == BYTE_W'(FRAME_BYTES - 2)) ? crc_q : data_q[7:0];

    // ----------------------------------------------------------
    // Bit period, bit index and byte index counters
    // ----------------------------------------------------------
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            busy_q <= 1'b0;
            cyc_q  <= '0;
            bit_q  <= '0;
            byte_q <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            cyc_q  <= '0;
            bit_q  <= '0;
            byte_q <= '0;
        end else if (busy_q) begin
            cyc_q <= bit_end ? '0 : cyc_q + 1'b1;
            if (byte_end) begin
                bit_q <= '0;
                // Last stop bit done
                if (byte_q == BYTE_W'(FRAME_BYTES - 1)) begin
                    busy_q <= 1'b0;
                end else begin
                    byte_q <= byte_q + 1'b1;
                end
            end else if (bit_end) begin
                bit_q <= bit_q + 1'b1;
            end
        end
    end

    // ----------------------------------------------------------
    // Byte shifter and running CRC
    // ----------------------------------------------------------
    always_ff @(posedge sys_clk) begin
        if (accept) begin
            // Header first, high start bit in bit 0
            sh_q   <= {1'b0, tx_frame.header, 1'b1};
            data_q <= tx_frame.data;
            crc_q  <= crc8_byte(CRC_INIT, tx_frame.header);
        end else if (byte_end) begin
            sh_q   <= {1'b0, next_byte, 1'b1};
            data_q <= data_q >> 8;
            // Fold each data byte in as it is loaded
            if (byte_q < BYTE_W'(DATA_BYTES)) begin
                crc_q <= crc8_byte(crc_q, data_q[7:0]);
            end
        end else if (bit_end) begin
            sh_q <= sh_q >> 1;
        end
    end

    // Same enable on txen and busy
    assign tx_busy   = busy_q;
    assign line_txen = busy_q;
    // Line idles low
    assign line_tx   = busy_q & sh_q[0];

endmodule

// File: rtl/mbus_rx_deserializer.sv
`timescale 1ns/1ns
// ----------------------------------------------------------
// Frame receiver on the ORed bus line, mid-bit sampling
// No resync inside a byte, so line skew must stay well under half a bit
// ----------------------------------------------------------
module mbus_rx_deserializer (
    input  logic               sys_clk,
    input  logic               reset,
    input  logic               line_rx,
    output logic               rx_valid,
    output mbus_pkg::mbus_rx_t rx_data
);
    import mbus_pkg::*;

    logic [1:0]              sync_q;
    logic                    prev_q;
    logic                    line_s;
    logic                    rise;
    logic                    active_q;
    logic [CYC_W-1:0]        cyc_q;
    logic [BIT_W-1:0]        bit_q;
    logic [BYTE_W-1:0]       byte_q;
    logic                    sample;
    logic                    stop_ok;
    logic                    last_byte;
    logic [7:0]              sh_q;
    // Header and data bytes, header ends up in the low byte
    logic [DATA_BYTES*8+7:0] buf_q;
    logic [7:0]              crc_q;
    logic [7:0]              crc_base;
    logic                    valid_q;

    // Two flop synchronizer output
    assign line_s    = sync_q[1];
    assign rise      = line_s && !prev_q;
    assign sample    = active_q && (cyc_q == CYC_W'(SAMPLE_AT - 1));
    assign stop_ok   = sample && (bit_q == BIT_W'(BYTE_BITS - 1)) && !line_s;
    assign last_byte = (byte_q == BYTE_W'(FRAME_BYTES - 1));
    // Fresh CRC on the header byte
    assign crc_base  = (byte_q == '0) ? CRC_INIT : crc_q;

    // ----------------------------------------------------------
    // Edge detect and bit sequencing
    // ----------------------------------------------------------
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            sync_q   <= '0;
            prev_q   <= 1'b0;
            active_q <= 1'b0;
            cyc_q    <= '0;
            bit_q    <= '0;
            byte_q   <= '0;
            valid_q  <= 1'b0;
        end else begin
            sync_q  <= {sync_q[0], line_rx};
            prev_q  <= line_s;
            valid_q <= 1'b0;
            if (!active_q) begin
                // Start edge opens a byte
                if (rise) begin
                    active_q <= 1'b1;
                    cyc_q    <= '0;
                    bit_q    <= '0;
                end
            end else begin
                cyc_q <= (cyc_q == CYC_W'(BIT_CYCLES - 1)) ? '0 : cyc_q + 1'b1;
                if (sample) begin
                    if (bit_q == '0 && !line_s) begin
                        // Start glitch
                        active_q <= 1'b0;
                        byte_q   <= '0;
                    end else if (bit_q == BIT_W'(BYTE_BITS - 1)) begin
                        active_q <= 1'b0;
                        if (line_s) begin
                            // Bad stop bit, drop the frame
                            byte_q <= '0;
                        end else if (last_byte) begin
                            byte_q  <= '0;
                            valid_q <= 1'b1;
                        end else begin
                            byte_q <= byte_q + 1'b1;
                        end
                    end else begin
                        bit_q <= bit_q + 1'b1;
                    end
                end
            end
        end
    end

    // ----------------------------------------------------------
    // Byte assembly, frame buffer and CRC check
    // ----------------------------------------------------------
    always_ff @(posedge sys_clk) begin
        // LSB first, data bits only
        if (sample && bit_q != '0 && bit_q != BIT_W'(BYTE_BITS - 1)) begin
            sh_q <= {line_s, sh_q[7:1]};
        end
        if (stop_ok) begin
            if (last_byte) begin
                rx_data.frame.header <= buf_q[7:0];
                rx_data.frame.data   <= buf_q[DATA_BYTES*8+7:8];
                rx_data.crc_err      <= (sh_q != crc_q);
            end else begin
                buf_q <= {sh_q, buf_q[DATA_BYTES*8+7:8]};
                crc_q <= crc8_byte(crc_base, sh_q);
            end
        end
    end

    assign rx_valid = valid_q;

endmodule

// File: rtl/mbus_link_stats.sv
`timescale 1ns/1ns
// ----------------------------------------------------------
// Good and bad frame counters, both stick at all ones
// ----------------------------------------------------------
module mbus_link_stats (
    input  logic                  sys_clk,
    input  logic                  reset,
    input  logic                  rx_valid,
    input  logic                  crc_err,
    output mbus_pkg::mbus_stats_t stats,
    output logic                  link_led
);
    import mbus_pkg::*;

    logic [COUNT_W-1:0] good_q;
    logic [COUNT_W-1:0] err_q;
    // Result of the most recent frame
    logic               led_q;

    // ----------------------------------------------------------
    // Counters, one cycle behind rx_valid
    // ----------------------------------------------------------
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            good_q <= '0;
            err_q  <= '0;
            led_q  <= 1'b0;
        end else if (rx_valid) begin
            if (crc_err) begin
                // Saturate
                if (err_q != '1) begin
                    err_q <= err_q + 1'b1;
                end
                led_q <= 1'b0;
            end else begin
                if (good_q != '1) begin
                    good_q <= good_q + 1'b1;
                end
                led_q <= 1'b1;
            end
        end
    end

    assign stats    = '{good_count: good_q, err_count: err_q};
    assign link_led = led_q;

endmodule

// File: rtl/mbus_link_top.sv
`timescale 1ns/1ns
// ----------------------------------------------------------
// Station bus link, both lines carry the same stream
// Receive uses the wired OR of the two lines, idle low
// ----------------------------------------------------------
module mbus_link_top (
    input  logic                  sys_clk,
    input  logic                  reset,
    input  logic                  tx_req,
    input  mbus_pkg::mbus_frame_t tx_frame,
    input  logic                  mb_rx1,
    input  logic                  mb_rx2,
    output logic                  tx_busy,
    output logic                  mb_tx1,
    output logic                  mb_txen1,
    output logic                  mb_tx2,
    output logic                  mb_txen2,
    output logic                  rx_valid,
    output mbus_pkg::mbus_rx_t    rx_data,
    output mbus_pkg::mbus_stats_t stats,
    output logic                  link_led
);

    logic line_tx;
    logic line_txen;
    logic line_rx;

    // ----------------------------------------------------------
    // Line pins
    // ----------------------------------------------------------
    assign line_rx  = mb_rx1 | mb_rx2;
    assign mb_tx1   = line_tx;
    assign mb_txen1 = line_txen;
    assign mb_tx2   = line_tx;
    assign mb_txen2 = line_txen;

    // ----------------------------------------------------------
    // Link blocks
    // ----------------------------------------------------------
    mbus_tx_serializer u_tx (
        .sys_clk   (sys_clk),
        .reset     (reset),
        .tx_req    (tx_req),
        .tx_frame  (tx_frame),
        .tx_busy   (tx_busy),
        .line_tx   (line_tx),
        .line_txen (line_txen)
    );

    mbus_rx_deserializer u_rx (
        .sys_clk  (sys_clk),
        .reset    (reset),
        .line_rx  (line_rx),
        .rx_valid (rx_valid),
        .rx_data  (rx_data)
    );

    // Only the check result feeds the counters
    mbus_link_stats u_stats (
        .sys_clk  (sys_clk),
        .reset    (reset),
        .rx_valid (rx_valid),
        .crc_err  (rx_data.crc_err),
        .stats    (stats),
        .link_led (link_led)
    );

endmodule

// File: verif/mbus_link_sva.sv
`timescale 1ns/1ns
// ----------------------------------------------------------
// Transmit line protocol checks, bound into every transmitter
// ----------------------------------------------------------
module mbus_link_sva (
    input logic sys_clk,
    input logic reset,
    input logic tx_req,
    input logic tx_busy,
    input logic line_tx,
    input logic line_txen
);
    import mbus_pkg::*;

    localparam int FRAME_CYCLES = FRAME_BYTES * BYTE_BITS * BIT_CYCLES;

    // Cycles with the enable high in the current burst
    int high_cnt;

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            high_cnt <= 0;
        end else if (line_txen) begin
            high_cnt <= high_cnt + 1;
        end else begin
            high_cnt <= 0;
        end
    end

    // Line idles low
    a_idle_low: assert property (@(posedge sys_clk) disable iff (reset)
        !line_txen |-> !line_tx) else $error("line_tx high without line_txen");

    a_busy_is_txen: assert property (@(posedge sys_clk) disable iff (reset)
        tx_busy == line_txen) else $error("tx_busy differs from line_txen");

    a_req_starts: assert property (@(posedge sys_clk) disable iff (reset)
        tx_req && !tx_busy |=> line_txen) else $error("accepted tx_req without line_txen");

    // One frame per burst, no more and no less
    a_burst_max: assert property (@(posedge sys_clk) disable iff (reset)
        line_txen |-> high_cnt < FRAME_CYCLES) else $error("line_txen burst too long");

    a_burst_len: assert property (@(posedge sys_clk) disable iff (reset)
        $fell(line_txen) |-> high_cnt == FRAME_CYCLES) else $error("line_txen burst length");

endmodule

bind mbus_tx_serializer mbus_link_sva u_sva (
    .sys_clk   (sys_clk),
    .reset     (reset),
    .tx_req    (tx_req),
    .tx_busy   (tx_busy),
    .line_tx   (line_tx),
    .line_txen (line_txen)
);

// File: verif/tb_mbus_link.sv
`timescale 1ns/1ns
// ----------------------------------------------------------
// Directed tests of the link over a line loopback model
// Loopback has no skew, corruption applies to line 1 only
// ----------------------------------------------------------
module tb_mbus_link;
    import mbus_pkg::*;

    localparam int CLK_NS       = 4;
    localparam int FRAME_CYCLES = FRAME_BYTES * BYTE_BITS * BIT_CYCLES;
    // Nine frames plus one frame time of idle watching
    localparam int N_FRAMES     = 10;
    localparam int WATCHDOG_NS  = (N_FRAMES + 4) * FRAME_CYCLES * CLK_NS + 2000;
    localparam int RX_LIMIT     = FRAME_CYCLES + 100;

    logic        sys_clk;
    logic        reset;
    logic        tx_req;
    mbus_frame_t tx_frame;
    logic        mb_rx1;
    logic        mb_rx2;
    logic        tx_busy;
    logic        mb_tx1;
    logic        mb_txen1;
    logic        mb_tx2;
    logic        mb_txen2;
    logic        rx_valid;
    mbus_rx_t    rx_data;
    mbus_stats_t stats;
    logic        link_led;

    // Loopback controls
    logic        en1;
    logic        en2;
    logic        flip;
    logic [15:0] lfsr_q;
    int          value_errs;
    int          other_errs;
    mbus_stats_t exp_stats;

    mbus_link_top dut0 (.*);

    // ----------------------------------------------------------
    // Clock, loopback and watchdog
    // ----------------------------------------------------------
    initial begin
        sys_clk = 1'b0;
        forever #(CLK_NS / 2) sys_clk = ~sys_clk;
    end

    assign mb_rx1 = en1 & mb_txen1 & (mb_tx1 ^ flip);
    assign mb_rx2 = en2 & mb_txen2 & mb_tx2;

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t ns, tests did not complete", $time);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ----------------------------------------------------------
    // Stimulus and reference model
    // ----------------------------------------------------------
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_frame(output mbus_frame_t f);
        logic [39:0] v;
        for (int i = 0; i < 40; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v[i]   = lfsr_q[0];
        end
        f = v;
    endtask

    // CRC-8 one bit at a time, poly 0x07, MSB first
    function automatic logic [7:0] crc_update(input logic [7:0] crc, input logic [7:0] d);
        logic [7:0] c;
        logic       fb;
        c = crc;
        for (int i = 7; i >= 0; i--) begin
            fb = c[7] ^ d[i];
            c  = {c[6:0], 1'b0} ^ (fb ? 8'h07 : 8'h00);
        end
        return c;
    endfunction

    function automatic logic [7:0] frame_crc(input mbus_frame_t f);
        logic [7:0] c;
        c = crc_update(8'h00, f.header);
        for (int k = 0; k < DATA_BYTES; k++) begin
            c = crc_update(c, f.data[k*8 +: 8]);
        end
        return c;
    endfunction

    // Expected line level in bit period p of the frame
    function automatic logic line_bit(input mbus_frame_t f, input int p);
        int         b;
        int         j;
        logic [7:0] v;
        b = p / BYTE_BITS;
        j = p % BYTE_BITS;
        if (b == 0) begin
            v = f.header;
        end else if (b == FRAME_BYTES - 1) begin
            v = frame_crc(f);
        end else begin
            v = f.data[(b-1)*8 +: 8];
        end
        if (j == 0) begin
            return 1'b1;
        end else if (j == BYTE_BITS - 1) begin
            return 1'b0;
        end
        return v[j-1];
    endfunction

    // ----------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------
    task automatic check_frame(input string name, input mbus_rx_t got, input mbus_rx_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_stats(input string name, input mbus_stats_t got,
                               input mbus_stats_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("[FAIL] %0t %s got good %0d err %0d expected good %0d err %0d",
                     $time, name, got.good_count, got.err_count,
                     exp.good_count, exp.err_count);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            value_errs++;
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // ----------------------------------------------------------
    // Bus helpers
    // ----------------------------------------------------------
    // Returns on the edge where the transmitter takes the request
    task automatic send_frame(input mbus_frame_t f);
        @(posedge sys_clk);
        tx_req   <= 1'b1;
        tx_frame <= f;
        @(posedge sys_clk);
        tx_req   <= 1'b0;
    endtask

    task automatic wait_rx(output mbus_rx_t got);
        int n;
        n   = 0;
        got = '0;
        do begin
            @(negedge sys_clk);
            n++;
        end while (!rx_valid && n < RX_LIMIT);
        if (!rx_valid) begin
            other_errs++;
            $display("No rx_valid within %0d cycles at %0t ns", RX_LIMIT, $time);
        end else begin
            got = rx_data;
        end
        // Counters settle one cycle later
        @(negedge sys_clk);
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge sys_clk);
        while (tx_busy && n < RX_LIMIT) begin
            @(negedge sys_clk);
            n++;
        end
        if (tx_busy) begin
            other_errs++;
            $display("Transmitter still busy after %0d cycles at %0t ns", n, $time);
        end
    endtask

    // Send one frame and check that it comes back as expected
    task automatic loop_frame(input mbus_frame_t f, input string name);
        mbus_rx_t got;
        send_frame(f);
        wait_rx(got);
        exp_stats.good_count++;
        check_frame({name, ".rx_data"}, got, '{frame: f, crc_err: 1'b0});
        check_stats({name, ".stats"}, stats, exp_stats);
        check_bit({name, ".link_led"}, link_led, 1'b1);
        wait_idle();
    endtask

    // ----------------------------------------------------------
    // Tests
    // ----------------------------------------------------------
    task automatic single_line_test();
        mbus_frame_t f;
        en1 <= 1'b1;
        en2 <= 1'b0;
        random_frame(f);
        loop_frame(f, "single");
    endtask

    task automatic dual_line_test();
        mbus_frame_t f;
        en1 <= 1'b1;
        en2 <= 1'b1;
        for (int i = 0; i < 4; i++) begin
            random_frame(f);
            loop_frame(f, "dual");
        end
    endtask

    task automatic busy_request_test();
        mbus_frame_t f1;
        mbus_frame_t f2;
        mbus_rx_t    got;
        random_frame(f1);
        random_frame(f2);
        send_frame(f1);
        repeat (20) @(posedge sys_clk);
        // Second request lands mid frame
        tx_req   <= 1'b1;
        tx_frame <= f2;
        @(posedge sys_clk);
        tx_req   <= 1'b0;
        wait_rx(got);
        exp_stats.good_count++;
        check_frame("busy.rx_data", got, '{frame: f1, crc_err: 1'b0});
        wait_idle();
        // Nothing else may follow
        for (int n = 0; n < FRAME_CYCLES; n++) begin
            @(negedge sys_clk);
            check_bit("busy.rx_valid", rx_valid, 1'b0);
            check_bit("busy.tx_busy", tx_busy, 1'b0);
        end
        check_stats("busy.stats", stats, exp_stats);
    endtask

    task automatic crc_error_test();
        mbus_frame_t f;
        mbus_frame_t bad;
        mbus_rx_t    got;
        en1 <= 1'b1;
        en2 <= 1'b0;
        random_frame(f);
        bad = f;
        // Frame byte 2 is data byte 1, flip its bit 3
        bad.data[8+3] = ~bad.data[8+3];
        send_frame(f);
        repeat ((2 * BYTE_BITS + 1 + 3) * BIT_CYCLES) @(posedge sys_clk);
        flip <= 1'b1;
        repeat (BIT_CYCLES) @(posedge sys_clk);
        flip <= 1'b0;
        wait_rx(got);
        exp_stats.err_count++;
        check_frame("crc.rx_data", got, '{frame: bad, crc_err: 1'b1});
        check_stats("crc.stats", stats, exp_stats);
        check_bit("crc.link_led", link_led, 1'b0);
        wait_idle();
        random_frame(f);
        loop_frame(f, "crc_clean");
    endtask

    task automatic tx_timing_test();
        mbus_frame_t f;
        mbus_rx_t    got;
        int          n;
        logic        seen;
        en1 <= 1'b1;
        en2 <= 1'b1;
        random_frame(f);
        got  = '0;
        seen = 1'b0;
        @(posedge sys_clk);
        tx_req   <= 1'b1;
        tx_frame <= f;
        @(negedge sys_clk);
        check_bit("timing.mb_txen1", mb_txen1, 1'b0);
        @(posedge sys_clk);
        tx_req <= 1'b0;
        n = 0;
        @(negedge sys_clk);
        check_bit("timing.mb_txen1", mb_txen1, 1'b1);
        while (mb_txen1 && n <= FRAME_CYCLES) begin
            check_bit("timing.mb_txen2", mb_txen2, 1'b1);
            check_bit("timing.mb_tx2", mb_tx2, mb_tx1);
            check_bit("timing.mb_tx1", mb_tx1, line_bit(f, n / BIT_CYCLES));
            // Receiver reports mid last stop bit, before txen falls
            if (rx_valid) begin
                seen = 1'b1;
                got  = rx_data;
            end
            n++;
            @(negedge sys_clk);
        end
        check_count("timing.txen_cycles", n, FRAME_CYCLES);
        check_bit("timing.mb_txen2", mb_txen2, 1'b0);
        if (!seen) begin
            other_errs++;
            $display("No rx_valid while the timed frame was on the line at %0t ns", $time);
        end
        exp_stats.good_count++;
        check_frame("timing.rx_data", got, '{frame: f, crc_err: 1'b0});
        check_stats("timing.stats", stats, exp_stats);
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        reset      = 1'b1;
        tx_req     = 1'b0;
        tx_frame   = '0;
        en1        = 1'b0;
        en2        = 1'b0;
        flip       = 1'b0;
        lfsr_q     = 16'd23;
        value_errs = 0;
        other_errs = 0;
        exp_stats  = '0;
        repeat (8) @(posedge sys_clk);
        reset <= 1'b0;
        @(negedge sys_clk);
        check_stats("reset.stats", stats, exp_stats);
        check_bit("reset.link_led", link_led, 1'b0);
        check_bit("reset.mb_txen1", mb_txen1, 1'b0);
        single_line_test();
        dual_line_test();
        busy_request_test();
        crc_error_test();
        tx_timing_test();
        $display("Errors: %0d wrong values, %0d other failures", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: list.f
rtl/mbus_pkg.sv
rtl/mbus_tx_serializer.sv
rtl/mbus_rx_deserializer.sv
rtl/mbus_link_stats.sv
rtl/mbus_link_top.sv
verif/mbus_link_sva.sv
verif/tb_mbus_link.sv

// File: Bender.yml
package:
  name: mbus_link

sources:
  # Design, package first
  - files:
      - rtl/mbus_pkg.sv
      - rtl/mbus_tx_serializer.sv
      - rtl/mbus_rx_deserializer.sv
      - rtl/mbus_link_stats.sv
      - rtl/mbus_link_top.sv
  # Verification
  - target: test
    files:
      - verif/mbus_link_sva.sv
      - verif/tb_mbus_link.sv
